// File: pipe_ctrl.f
source/pipe_ctrl_pkg.sv
source/instr_decoder.sv
source/hazard_queue.sv
source/forward_select.sv
source/stall_ctrl.sv
source/pipe_ctrl_top.sv
testbench/tb_pipe_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the pipeline controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_pipe_ctrl -f pipe_ctrl.f -o sim_pipe_ctrl

# the simulator exits nonzero on a failed check, the search below decides
out=$(./obj_dir/sim_pipe_ctrl) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: source/forward_select.sv
/*
 * forwarding select
 * picks the nearest in-flight producer for rs1 and rs2
 */
`timescale 1ns/1ps

module forward_select
    import pipe_ctrl_pkg::*;
(
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  src_use_t  i_src_use,
    input  reg_addr_t i_rd_de,
    input  reg_addr_t i_rd_exe,
    input  reg_addr_t i_rd_mem,
    output fwd_sel_t  o_rs1_sel,
    output fwd_sel_t  o_rs2_sel
);

    // closest writer wins, x0 never forwards
    function automatic fwd_sel_t pick_src(input reg_addr_t rs, input logic used);
        fwd_sel_t sel;
        sel = fwd_reg_data;
        if (used && rs != reg_addr_t'(ZERO_REG)) begin
            if (rs == i_rd_de) begin
                sel = fwd_exe;
            end else if (rs == i_rd_exe) begin
                sel = fwd_mem;
            end else if (rs == i_rd_mem) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    always_comb begin
        o_rs1_sel = pick_src(i_rs1, i_src_use.uses_rs1);
        o_rs2_sel = pick_src(i_rs2, i_src_use.uses_rs2);
    end

endmodule

// File: source/hazard_queue.sv
/*
 * hazard queue
 * destination registers of the instructions in de, exe and mem
 */
`timescale 1ns/1ps

module hazard_queue
    import pipe_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_load,
    input  logic      i_flush,
    input  reg_addr_t i_rd,
    output reg_addr_t o_rd_de,
    output reg_addr_t o_rd_exe,
    output reg_addr_t o_rd_mem
);

    // entry 0 is the youngest
    reg_addr_t rd_q [HZD_DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < HZD_DEPTH; i++) begin
                rd_q[i] <= reg_addr_t'(ZERO_REG);
            end
        end else if (i_flush) begin
            // wrong-path writers must not forward
            for (int i = 0; i < HZD_DEPTH; i++) begin
                rd_q[i] <= reg_addr_t'(ZERO_REG);
            end
        end else if (i_load) begin
            rd_q[0] <= i_rd;
            for (int i = 1; i < HZD_DEPTH; i++) begin
                rd_q[i] <= rd_q[i-1];
            end
        end
    end

    assign o_rd_de  = rd_q[0];
    assign o_rd_exe = rd_q[1];
    assign o_rd_mem = rd_q[2];

endmodule

// File: source/instr_decoder.sv
/*
 * instruction decoder
 * builds the exe, mem and wb control word for the decode-stage
 * instruction and flags which source registers it reads
 */
`timescale 1ns/1ps

module instr_decoder
    import pipe_ctrl_pkg::*;
(
    input  rv_instr_t  i_instr,
    input  logic       i_de_rdy,
    output ctrl_word_t o_ctrl,
    output src_use_t   o_src_use
);

    logic is_reg;

    assign is_reg = (i_instr.opcode == op_reg);

    always_comb begin
        o_ctrl = CTRL_DEFAULT;
        o_src_use = '0;

        if (i_de_rdy) begin
            case (i_instr.opcode)
                op_lui: begin
                    o_ctrl.exe.exe_fwd_sel = exe_fwd_u_imm;
                    o_ctrl.mem.mem_fwd_sel = mem_fwd_exe_data;
                    o_ctrl.wb.ld_reg = 1'b1;
                    o_ctrl.wb.regfile_sel = rf_u_imm;
                end

                op_auipc: begin
                    o_ctrl.exe.alu_mux1_sel = alu1_pc_out;
                    o_ctrl.exe.alu_mux2_sel = alu2_u_imm;
                    o_ctrl.mem.mem_fwd_sel = mem_fwd_exe_data;
                    o_ctrl.wb.ld_reg = 1'b1;
                end

                op_jal: begin
                    // target from the alu, link value from pc + 4
                    o_ctrl.exe.alu_mux1_sel = alu1_pc_out;
                    o_ctrl.exe.alu_mux2_sel = alu2_j_imm;
                    o_ctrl.mem.mem_fwd_sel = mem_fwd_exe_data;
                    o_ctrl.wb.ld_reg = 1'b1;
                    o_ctrl.wb.regfile_sel = rf_pc_plus4;
                end

                op_jalr: begin
                    o_ctrl.mem.mem_fwd_sel = mem_fwd_exe_data;
                    o_ctrl.wb.ld_reg = 1'b1;
                    o_ctrl.wb.regfile_sel = rf_pc_plus4;
                    o_src_use.uses_rs1 = 1'b1;
                end

                op_br: begin
                    // funct3 010/011 are not branches, keep beq
                    if (i_instr.funct3[2:1] != 2'b01) begin
                        o_ctrl.exe.cmp_op = cmp_op_t'(i_instr.funct3);
                    end
                    o_ctrl.exe.alu_mux1_sel = alu1_pc_out;
                    o_ctrl.exe.alu_mux2_sel = alu2_b_imm;
                    o_ctrl.mem.mem_fwd_sel = mem_fwd_exe_data;
                    o_src_use.uses_rs1 = 1'b1;
                    o_src_use.uses_rs2 = 1'b1;
                end

                op_load: begin
                    o_ctrl.mem.mem_read = 1'b1;
                    o_ctrl.mem.funct3 = i_instr.funct3;
                    o_ctrl.mem.mar_sel = mar_alu_out;
                    o_ctrl.wb.ld_reg = 1'b1;
                    case (i_instr.funct3)
                        3'b000: o_ctrl.wb.regfile_sel = rf_lb;
                        3'b001: o_ctrl.wb.regfile_sel = rf_lh;
                        3'b010: o_ctrl.wb.regfile_sel = rf_lw;
                        3'b100: o_ctrl.wb.regfile_sel = rf_lbu;
                        3'b101: o_ctrl.wb.regfile_sel = rf_lhu;
                        default: ;
                    endcase
                    o_src_use.uses_rs1 = 1'b1;
                end

                op_store: begin
                    o_ctrl.exe.alu_mux2_sel = alu2_s_imm;
                    o_ctrl.mem.mem_write = 1'b1;
                    o_ctrl.mem.funct3 = i_instr.funct3;
                    o_ctrl.mem.mar_sel = mar_alu_out;
                    o_src_use.uses_rs1 = 1'b1;
                    o_src_use.uses_rs2 = 1'b1;
                end

                op_imm, op_reg: begin
                    // second operand is the immediate or rs2
                    o_ctrl.exe.alu_mux2_sel = is_reg ? alu2_rs2_out : alu2_i_imm;
                    o_ctrl.exe.cmp_sel = is_reg ? cmp_rs2_out : cmp_i_imm;
                    o_ctrl.mem.mem_fwd_sel = mem_fwd_exe_data;
                    o_ctrl.wb.ld_reg = 1'b1;
                    o_src_use.uses_rs1 = 1'b1;
                    o_src_use.uses_rs2 = is_reg;
                    case (i_instr.funct3)
                        3'b000: begin
                            // no subi, funct7 only matters for op-reg
                            if (is_reg && i_instr.funct7[5]) begin
                                o_ctrl.exe.alu_op = alu_sub;
                            end
                        end
                        3'b001: o_ctrl.exe.alu_op = alu_sll;
                        3'b010, 3'b011: begin
                            // slt and sltu go through the comparator
                            o_ctrl.exe.cmp_op = i_instr.funct3[0] ? cmp_bltu : cmp_blt;
                            o_ctrl.exe.exe_fwd_sel = exe_fwd_br_en_zext;
                            o_ctrl.wb.regfile_sel = rf_br_en;
                        end
                        3'b100: o_ctrl.exe.alu_op = alu_xor;
                        3'b101: begin
                            o_ctrl.exe.alu_op = i_instr.funct7[5] ? alu_sra : alu_srl;
                        end
                        3'b110: o_ctrl.exe.alu_op = alu_or;
                        default: o_ctrl.exe.alu_op = alu_and;
                    endcase
                end

                default: ;
            endcase

            // branches and stores enqueue x0
            if (o_ctrl.wb.ld_reg) begin
                o_ctrl.wb.rd_sel = i_instr.rd;
            end
        end
    end

endmodule

// File: source/pipe_ctrl_pkg.sv
/*
 * pipeline control package
 * shared widths, instruction fields, mux selects and control word
 * types for the five-stage rv32i controller
 */
package pipe_ctrl_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int XLEN       = 32;
    localparam int NUM_STAGES = 5;
    localparam int NUM_PPR    = 4;
    localparam int HZD_DEPTH  = 3;
    localparam int ZERO_REG   = 0;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // r-format view, funct7 takes what is left of the word
    typedef struct packed {
        logic [XLEN-3*REG_ADDR_W-3-7-1:0] funct7;
        reg_addr_t                        rs2;
        reg_addr_t                        rs1;
        logic [2:0]                       funct3;
        reg_addr_t                        rd;
        opcode_t                          opcode;
    } rv_instr_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_sll, alu_srl, alu_sra, alu_xor, alu_or, alu_and
    } alu_op_t;

    // same codes as branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {alu1_rs1_out, alu1_pc_out} alu_mux1_t;
    typedef enum logic [2:0] {
        alu2_i_imm, alu2_u_imm, alu2_b_imm, alu2_s_imm, alu2_j_imm, alu2_rs2_out
    } alu_mux2_t;
    typedef enum logic {cmp_rs2_out, cmp_i_imm} cmp_mux_t;
    typedef enum logic [1:0] {exe_fwd_alu_out, exe_fwd_br_en_zext, exe_fwd_u_imm} exe_fwd_mux_t;
    typedef enum logic [1:0] {fwd_reg_data, fwd_exe, fwd_mem, fwd_wb} fwd_sel_t;

    typedef enum logic {mar_pc_out, mar_alu_out} mar_mux_t;
    typedef enum logic {mem_fwd_mem_data, mem_fwd_exe_data} mem_fwd_mux_t;
    typedef enum logic [3:0] {
        rf_alu_out, rf_br_en, rf_u_imm, rf_pc_plus4, rf_lb, rf_lh, rf_lw, rf_lbu, rf_lhu
    } regfile_mux_t;
    typedef enum logic [1:0] {pc_plus4, pc_alu_out, pc_alu_mod2} pc_mux_t;

    typedef struct packed {
        alu_op_t      alu_op;
        cmp_op_t      cmp_op;
        alu_mux1_t    alu_mux1_sel;
        alu_mux2_t    alu_mux2_sel;
        cmp_mux_t     cmp_sel;
        exe_fwd_mux_t exe_fwd_sel;
        fwd_sel_t     rs1_sel;
        fwd_sel_t     rs2_sel;
    } exe_ctrl_t;

    typedef struct packed {
        logic         mem_read;
        logic         mem_write;
        logic [2:0]   funct3;
        mar_mux_t     mar_sel;
        mem_fwd_mux_t mem_fwd_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic         ld_reg;
        regfile_mux_t regfile_sel;
        reg_addr_t    rd_sel;
    } wb_ctrl_t;

    typedef struct packed {
        exe_ctrl_t exe;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ctrl_word_t;

    typedef struct packed {
        logic uses_rs1;
        logic uses_rs2;
    } src_use_t;

    // index 4 is fetch, 0 is writeback
    typedef logic [NUM_STAGES-1:0] stage_vec_t;
    // index 3 is if_de, 0 is mem_wb
    typedef logic [NUM_PPR-1:0] ppr_vec_t;

    // idle word, a bubble through every stage
    localparam ctrl_word_t CTRL_DEFAULT = '{
        exe: '{
            alu_op: alu_add,
            cmp_op: cmp_beq,
            alu_mux1_sel: alu1_rs1_out,
            alu_mux2_sel: alu2_i_imm,
            cmp_sel: cmp_rs2_out,
            exe_fwd_sel: exe_fwd_alu_out,
            rs1_sel: fwd_reg_data,
            rs2_sel: fwd_reg_data
        },
        mem: '{
            mem_read: 1'b0,
            mem_write: 1'b0,
            funct3: 3'b000,
            mar_sel: mar_pc_out,
            mem_fwd_sel: mem_fwd_mem_data
        },
        wb: '{
            ld_reg: 1'b0,
            regfile_sel: rf_alu_out,
            rd_sel: reg_addr_t'(ZERO_REG)
        }
    };

endpackage

// File: source/pipe_ctrl_top.sv
/*
 * pipeline controller top
 * decoder, hazard queue, forwarding select and stall control
 */
`timescale 1ns/1ps

module pipe_ctrl_top
    import pipe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rv_instr_t  i_instr,
    input  logic       i_de_rdy,
    input  logic       i_icache_resp,
    input  logic       i_br_en,
    input  opcode_t    i_exe_opcode,
    input  stage_vec_t i_rdy,
    input  stage_vec_t i_valid,
    output ctrl_word_t o_ctrl,
    output ppr_vec_t   o_ppr_ld,
    output ppr_vec_t   o_ppr_flush,
    output logic       o_imem_read,
    output logic       o_load_pc,
    output pc_mux_t    o_pcmux_sel
);

    ctrl_word_t dec_ctrl;
    src_use_t   src_use;
    reg_addr_t  rd_de;
    reg_addr_t  rd_exe;
    reg_addr_t  rd_mem;
    fwd_sel_t   rs1_sel;
    fwd_sel_t   rs2_sel;
    logic       hzd_load;
    logic       hzd_flush;

    instr_decoder i_instr_decoder (
        .i_instr   (i_instr),
        .i_de_rdy  (i_de_rdy),
        .o_ctrl    (dec_ctrl),
        .o_src_use (src_use)
    );

    hazard_queue i_hazard_queue (
        .clk      (clk),
        .rst      (rst),
        .i_load   (hzd_load),
        .i_flush  (hzd_flush),
        .i_rd     (dec_ctrl.wb.rd_sel),
        .o_rd_de  (rd_de),
        .o_rd_exe (rd_exe),
        .o_rd_mem (rd_mem)
    );

    forward_select i_forward_select (
        .i_rs1     (i_instr.rs1),
        .i_rs2     (i_instr.rs2),
        .i_src_use (src_use),
        .i_rd_de   (rd_de),
        .i_rd_exe  (rd_exe),
        .i_rd_mem  (rd_mem),
        .o_rs1_sel (rs1_sel),
        .o_rs2_sel (rs2_sel)
    );

    stall_ctrl i_stall_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_valid       (i_valid),
        .i_icache_resp (i_icache_resp),
        .i_br_en       (i_br_en),
        .i_exe_opcode  (i_exe_opcode),
        .o_ppr_ld      (o_ppr_ld),
        .o_ppr_flush   (o_ppr_flush),
        .o_hzd_load    (hzd_load),
        .o_hzd_flush   (hzd_flush),
        .o_imem_read   (o_imem_read),
        .o_load_pc     (o_load_pc),
        .o_pcmux_sel   (o_pcmux_sel)
    );

    // forwarding selects replace the decoder's reg_data defaults
    always_comb begin
        o_ctrl = dec_ctrl;
        o_ctrl.exe.rs1_sel = rs1_sel;
        o_ctrl.exe.rs2_sel = rs2_sel;
    end

endmodule

// File: source/stall_ctrl.sv
/*
 * stall and redirect control
 * pipeline register loads and flushes, fetch request, pc load
 * and next-pc select after branches and jumps
 */
`timescale 1ns/1ps

module stall_ctrl
    import pipe_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  stage_vec_t i_rdy,
    input  stage_vec_t i_valid,
    input  logic       i_icache_resp,
    input  logic       i_br_en,
    input  opcode_t    i_exe_opcode,
    output ppr_vec_t   o_ppr_ld,
    output ppr_vec_t   o_ppr_flush,
    output logic       o_hzd_load,
    output logic       o_hzd_flush,
    output logic       o_imem_read,
    output logic       o_load_pc,
    output pc_mux_t    o_pcmux_sel
);

    logic [NUM_PPR-1:0] stage_stall;
    ppr_vec_t   ppr_stall;
    logic       br_take;
    logic       jump_take;
    logic       br_taken_q;
    logic       jump_taken_q;

    // a stage holds its inputs while valid and not ready
    assign stage_stall = i_valid[NUM_PPR-1:0] & ~i_rdy[NUM_PPR-1:0];

    // register k stalls if any stage from k down to wb stalls
    always_comb begin
        ppr_stall[0] = stage_stall[0];
        for (int k = 1; k < NUM_PPR; k++) begin
            ppr_stall[k] = ppr_stall[k-1] | stage_stall[k];
        end
    end

    always_comb begin
        if (rst) begin
            o_ppr_ld = '0;
        end else begin
            o_ppr_ld[NUM_PPR-1] = i_icache_resp & ~ppr_stall[NUM_PPR-1];
            // later registers also need a valid stage feeding them
            for (int k = 0; k < NUM_PPR-1; k++) begin
                o_ppr_ld[k] = i_icache_resp & ~ppr_stall[k] & i_valid[k+1];
            end
        end
    end

    assign o_hzd_load = o_ppr_ld[NUM_PPR-1];

    assign br_take   = i_br_en && (i_exe_opcode == op_br);
    assign jump_take = (i_exe_opcode == op_jal) || (i_exe_opcode == op_jalr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            br_taken_q   <= 1'b0;
            jump_taken_q <= 1'b0;
        end else begin
            br_taken_q   <= br_take;
            jump_taken_q <= jump_take;
        end
    end

    // squash if_de, de_exe and exe_mem one cycle after the branch
    assign o_ppr_flush = rst ? '1 : {br_taken_q, br_taken_q, br_taken_q, 1'b0};
    assign o_hzd_flush = br_taken_q;

    assign o_imem_read = ~rst & ~i_icache_resp & ~ppr_stall[NUM_PPR-1];
    assign o_load_pc   = ~rst & ((i_icache_resp & br_taken_q) | jump_taken_q
                                 | ~ppr_stall[NUM_PPR-1]);

    always_comb begin
        if (br_take || i_exe_opcode == op_jal) begin
            o_pcmux_sel = pc_alu_out;
        end else if (i_exe_opcode == op_jalr) begin
            // jalr clears bit 0 of the target
            o_pcmux_sel = pc_alu_mod2;
        end else begin
            o_pcmux_sel = pc_plus4;
        end
    end

endmodule

// File: testbench/tb_pipe_ctrl.sv
/*
 * pipeline controller testbench
 * directed decode, forwarding, stall, branch and jump tests
 */
`timescale 1ns/1ps

module tb_pipe_ctrl
    import pipe_ctrl_pkg::*;
();

    // about 130 cycles of tests, wide margin on top
    localparam int MAX_CYCLES = 2000;

    logic       clk;
    logic       rst;
    rv_instr_t  i_instr;
    logic       i_de_rdy;
    logic       i_icache_resp;
    logic       i_br_en;
    opcode_t    i_exe_opcode;
    stage_vec_t i_rdy;
    stage_vec_t i_valid;
    ctrl_word_t o_ctrl;
    ppr_vec_t   o_ppr_ld;
    ppr_vec_t   o_ppr_flush;
    logic       o_imem_read;
    logic       o_load_pc;
    pc_mux_t    o_pcmux_sel;

    string cur_test;
    int    cycle_cnt = 0;

    pipe_ctrl_top i_pipe_ctrl_top (
        .clk           (clk),
        .rst           (rst),
        .i_instr       (i_instr),
        .i_de_rdy      (i_de_rdy),
        .i_icache_resp (i_icache_resp),
        .i_br_en       (i_br_en),
        .i_exe_opcode  (i_exe_opcode),
        .i_rdy         (i_rdy),
        .i_valid       (i_valid),
        .o_ctrl        (o_ctrl),
        .o_ppr_ld      (o_ppr_ld),
        .o_ppr_flush   (o_ppr_flush),
        .o_imem_read   (o_imem_read),
        .o_load_pc     (o_load_pc),
        .o_pcmux_sel   (o_pcmux_sel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            fail_now();
        end
    end

    task automatic fail_now;
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_ctrl(input string what, input ctrl_word_t exp, input ctrl_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_fwd(input string what, input fwd_sel_t exp, input fwd_sel_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_ppr(input string what, input ppr_vec_t exp, input ppr_vec_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_pc(input string what, input pc_mux_t exp, input pc_mux_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            fail_now();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
            fail_now();
        end
    endtask

    // inputs change 1 ns after the edge, outputs are read at the falling edge
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic sample;
        @(negedge clk);
    endtask

    function automatic rv_instr_t make_instr(input opcode_t op, input logic [2:0] f3,
                                             input logic [6:0] f7, input reg_addr_t rd,
                                             input reg_addr_t rs1, input reg_addr_t rs2);
        rv_instr_t ins;
        ins.opcode = op;
        ins.funct3 = f3;
        ins.funct7 = f7;
        ins.rd = rd;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        return ins;
    endfunction

    function automatic reg_addr_t rand_reg(input bit nonzero);
        if (nonzero) begin
            return reg_addr_t'(1 + $urandom % 31);
        end
        return reg_addr_t'($urandom % 32);
    endfunction

    // expected word from the decode rules
    function automatic ctrl_word_t exp_ctrl(input rv_instr_t ins);
        ctrl_word_t c;
        logic       is_reg;
        // idle word, every field at its first encoding
        c = '0;
        is_reg = (ins.opcode == op_reg);
        case (ins.opcode)
            op_lui: begin
                c.exe.exe_fwd_sel = exe_fwd_u_imm;
                c.wb.regfile_sel = rf_u_imm;
            end
            op_auipc: begin
                c.exe.alu_mux1_sel = alu1_pc_out;
                c.exe.alu_mux2_sel = alu2_u_imm;
            end
            op_jal: begin
                c.exe.alu_mux1_sel = alu1_pc_out;
                c.exe.alu_mux2_sel = alu2_j_imm;
                c.wb.regfile_sel = rf_pc_plus4;
            end
            op_jalr: c.wb.regfile_sel = rf_pc_plus4;
            op_br: begin
                c.exe.cmp_op = cmp_op_t'(ins.funct3);
                c.exe.alu_mux1_sel = alu1_pc_out;
                c.exe.alu_mux2_sel = alu2_b_imm;
            end
            op_load: begin
                c.mem.mem_read = 1'b1;
                c.mem.funct3 = ins.funct3;
                c.mem.mar_sel = mar_alu_out;
                case (ins.funct3)
                    3'd0: c.wb.regfile_sel = rf_lb;
                    3'd1: c.wb.regfile_sel = rf_lh;
                    3'd2: c.wb.regfile_sel = rf_lw;
                    3'd4: c.wb.regfile_sel = rf_lbu;
                    default: c.wb.regfile_sel = rf_lhu;
                endcase
            end
            op_store: begin
                c.exe.alu_mux2_sel = alu2_s_imm;
                c.mem.mem_write = 1'b1;
                c.mem.funct3 = ins.funct3;
                c.mem.mar_sel = mar_alu_out;
            end
            default: begin
                c.exe.alu_mux2_sel = is_reg ? alu2_rs2_out : alu2_i_imm;
                c.exe.cmp_sel = is_reg ? cmp_rs2_out : cmp_i_imm;
                case (ins.funct3)
                    3'd0: c.exe.alu_op = (is_reg && ins.funct7[5]) ? alu_sub : alu_add;
                    3'd1: c.exe.alu_op = alu_sll;
                    3'd2, 3'd3: begin
                        c.exe.cmp_op = ins.funct3[0] ? cmp_bltu : cmp_blt;
                        c.exe.exe_fwd_sel = exe_fwd_br_en_zext;
                        c.wb.regfile_sel = rf_br_en;
                    end
                    3'd4: c.exe.alu_op = alu_xor;
                    3'd5: c.exe.alu_op = ins.funct7[5] ? alu_sra : alu_srl;
                    3'd6: c.exe.alu_op = alu_or;
                    default: c.exe.alu_op = alu_and;
                endcase
            end
        endcase
        c.wb.ld_reg = (ins.opcode != op_br) && (ins.opcode != op_store);
        // results made in execute forward from the exe copy in memory
        if (ins.opcode != op_load && ins.opcode != op_store) begin
            c.mem.mem_fwd_sel = mem_fwd_exe_data;
        end
        if (c.wb.ld_reg) begin
            c.wb.rd_sel = ins.rd;
        end
        return c;
    endfunction

    function automatic rv_instr_t writer(input reg_addr_t rd);
        return make_instr(op_reg, 3'd0, 7'h00, rd, '0, '0);
    endfunction

    task automatic set_idle;
        i_de_rdy = 1'b1;
        i_icache_resp = 1'b0;
        i_br_en = 1'b0;
        i_exe_opcode = op_imm;
        i_rdy = '1;
        i_valid = '1;
    endtask

    task automatic decode_one(input opcode_t op, input logic [2:0] f3, input logic [6:0] f7);
        rv_instr_t ins;
        next_cycle();
        ins = make_instr(op, f3, f7, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
        i_instr = ins;
        sample();
        check_ctrl($sformatf("%s funct3 %0d funct7 %h", op.name(), f3, f7), exp_ctrl(ins),
                   o_ctrl);
    endtask

    // one writer enters the queue at the next edge
    task automatic push(input rv_instr_t ins);
        next_cycle();
        i_icache_resp = 1'b1;
        i_instr = ins;
    endtask

    // queue frozen while the cache has not responded
    task automatic consume(input opcode_t op, input reg_addr_t rs1, input reg_addr_t rs2,
                           input fwd_sel_t exp1, input fwd_sel_t exp2);
        next_cycle();
        i_icache_resp = 1'b0;
        i_instr = make_instr(op, 3'd0, 7'h00, '0, rs1, rs2);
        sample();
        check_fwd($sformatf("%s rs1 x%0d", op.name(), rs1), exp1, o_ctrl.exe.rs1_sel);
        check_fwd($sformatf("%s rs2 x%0d", op.name(), rs2), exp2, o_ctrl.exe.rs2_sel);
    endtask

    task automatic test_decode;
        cur_test = "decode";
        next_cycle();
        set_idle();
        decode_one(op_lui, 3'd0, 7'h00);
        decode_one(op_auipc, 3'd0, 7'h00);
        decode_one(op_jal, 3'd0, 7'h00);
        decode_one(op_jalr, 3'd0, 7'h00);
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                decode_one(op_br, 3'(f3), 7'h00);
            end
            if (f3 != 3 && f3 < 6) begin
                decode_one(op_load, 3'(f3), 7'h00);
            end
            if (f3 < 3) begin
                decode_one(op_store, 3'(f3), 7'h00);
            end
            decode_one(op_imm, 3'(f3), 7'h00);
            decode_one(op_imm, 3'(f3), 7'h20);
            decode_one(op_reg, 3'(f3), 7'h00);
            decode_one(op_reg, 3'(f3), 7'h20);
        end
        next_cycle();
        i_de_rdy = 1'b0;
        i_instr = make_instr(op_load, 3'd2, 7'h00, rand_reg(1'b1), rand_reg(1'b1), '0);
        sample();
        check_ctrl("decode not ready", '0, o_ctrl);
    endtask

    task automatic test_forwarding;
        reg_addr_t a;
        reg_addr_t b;
        reg_addr_t c;
        reg_addr_t d;
        cur_test = "forwarding";
        next_cycle();
        set_idle();
        a = rand_reg(1'b1);
        do b = rand_reg(1'b1); while (b == a);
        do c = rand_reg(1'b1); while (c == a || c == b);
        do d = rand_reg(1'b1); while (d == a || d == b || d == c);
        push(writer(a));
        push(writer(b));
        push(writer(c));
        consume(op_reg, c, b, fwd_exe, fwd_mem);
        consume(op_reg, a, d, fwd_wb, fwd_reg_data);
        // b now sits in de and mem, nearest one wins
        push(writer(b));
        consume(op_reg, b, c, fwd_exe, fwd_mem);
        consume(op_store, c, b, fwd_mem, fwd_exe);
    endtask

    task automatic test_no_forward;
        reg_addr_t p;
        reg_addr_t q;
        cur_test = "no forwarding";
        next_cycle();
        set_idle();
        p = rand_reg(1'b1);
        do q = rand_reg(1'b1); while (q == p);
        push(writer(p));
        push(make_instr(op_store, 3'd2, 7'h00, q, '0, '0));
        push(make_instr(op_br, 3'd0, 7'h00, q, '0, '0));
        consume(op_reg, q, q, fwd_reg_data, fwd_reg_data);
        consume(op_reg, '0, '0, fwd_reg_data, fwd_reg_data);
        consume(op_reg, q, p, fwd_reg_data, fwd_wb);
        consume(op_imm, p, p, fwd_wb, fwd_reg_data);
        consume(op_lui, p, p, fwd_reg_data, fwd_reg_data);
    endtask

    task automatic test_stall;
        int       s;
        ppr_vec_t exp;
        cur_test = "stall";
        next_cycle();
        set_idle();
        repeat (10) begin
            s = $urandom % NUM_STAGES;
            next_cycle();
            i_icache_resp = 1'b1;
            i_rdy = '1;
            i_rdy[s] = 1'b0;
            sample();
            // registers feeding the stalled stage and those before it hold
            for (int k = 0; k < NUM_PPR; k++) begin
                exp[k] = (k < s);
            end
            check_ppr($sformatf("stage %0d not ready", s), exp, o_ppr_ld);
            check_bit("fetch request with response", 1'b0, o_imem_read);
            next_cycle();
            i_icache_resp = 1'b0;
            sample();
            check_ppr("no cache response", '0, o_ppr_ld);
            check_bit($sformatf("fetch request stage %0d", s), s == NUM_STAGES - 1,
                      o_imem_read);
        end
        next_cycle();
        i_icache_resp = 1'b1;
        i_rdy = '1;
        i_valid = 5'b11011;
        sample();
        check_ppr("execute stage empty", 4'b1101, o_ppr_ld);
        next_cycle();
        i_valid = 5'b11110;
        i_rdy = 5'b11110;
        sample();
        check_ppr("idle writeback not ready", 4'b1111, o_ppr_ld);
    endtask

    task automatic test_branch;
        reg_addr_t r;
        cur_test = "branch";
        next_cycle();
        set_idle();
        r = rand_reg(1'b1);
        push(writer(r));
        next_cycle();
        i_icache_resp = 1'b0;
        i_instr = make_instr(op_reg, 3'd0, 7'h00, '0, r, '0);
        i_exe_opcode = op_br;
        sample();
        check_pc("branch not taken", pc_plus4, o_pcmux_sel);
        check_fwd("dependent before branch", fwd_exe, o_ctrl.exe.rs1_sel);
        next_cycle();
        i_br_en = 1'b1;
        sample();
        check_pc("branch taken", pc_alu_out, o_pcmux_sel);
        check_ppr("no flush in branch cycle", '0, o_ppr_flush);
        next_cycle();
        i_br_en = 1'b0;
        i_exe_opcode = op_imm;
        sample();
        check_ppr("flush after taken branch", 4'b1110, o_ppr_flush);
        next_cycle();
        sample();
        check_ppr("flush released", '0, o_ppr_flush);
        check_fwd("dependent after flush", fwd_reg_data, o_ctrl.exe.rs1_sel);
    endtask

    task automatic test_jump;
        cur_test = "jump";
        next_cycle();
        set_idle();
        next_cycle();
        i_exe_opcode = op_jal;
        sample();
        check_pc("jal", pc_alu_out, o_pcmux_sel);
        next_cycle();
        i_exe_opcode = op_jalr;
        sample();
        check_pc("jalr", pc_alu_mod2, o_pcmux_sel);
        next_cycle();
        i_exe_opcode = op_imm;
        i_rdy[3] = 1'b0;
        sample();
        check_bit("pc load with jump pending", 1'b1, o_load_pc);
        check_bit("fetch request while stalled", 1'b0, o_imem_read);
        next_cycle();
        sample();
        check_bit("pc load while stalled", 1'b0, o_load_pc);
        next_cycle();
        i_icache_resp = 1'b1;
        i_exe_opcode = op_br;
        i_br_en = 1'b1;
        sample();
        check_bit("pc load in branch cycle", 1'b0, o_load_pc);
        next_cycle();
        i_exe_opcode = op_imm;
        i_br_en = 1'b0;
        sample();
        check_bit("pc load after taken branch", 1'b1, o_load_pc);
        next_cycle();
        i_icache_resp = 1'b0;
        i_rdy = '1;
        sample();
        check_bit("pc load released", 1'b1, o_load_pc);
        check_bit("fetch request released", 1'b1, o_imem_read);
    endtask

    initial begin
        void'($urandom(93103));
        rst = 1'b1;
        i_instr = make_instr(op_imm, 3'd0, 7'h00, '0, '0, '0);
        set_idle();
        cur_test = "reset";
        @(negedge clk);
        check_ppr("loads in reset", '0, o_ppr_ld);
        check_ppr("flushes in reset", '1, o_ppr_flush);
        check_bit("fetch request in reset", 1'b0, o_imem_read);
        check_bit("pc load in reset", 1'b0, o_load_pc);
        @(posedge clk);
        #1;
        rst = 1'b0;
        sample();
        check_ppr("flushes after reset", '0, o_ppr_flush);
        test_decode();
        test_forwarding();
        test_no_forward();
        test_stall();
        test_branch();
        test_jump();
        $display("No errors");
        $finish;
    end

endmodule
